// ==== bus_system.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/axil_port.sv
verilog/bus_arbiter.sv
verilog/slave_decoder.sv
verilog/mem_slave.sv
verilog/response_mux.sv
verilog/bus_system.sv
sim/tb_clock_gen.sv
sim/bus_system_props.sv
sim/bus_system_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := bus_system_tb
FILELIST   := bus_system.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All checks passed
SOURCES    := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/bus_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module bus_system_tb;

    localparam int MASTERS     = `BUS_MASTER_COUNT;
    localparam int SLAVES      = `BUS_SLAVE_COUNT;
    localparam int ADDR_W      = `BUS_ADDR_WIDTH;
    localparam int SPAN        = 1 << (ADDR_W - 2);     // words behind one select code
    localparam int TXN_COUNT   = 51;                    // transactions over all tests
    localparam int TXN_CYCLES  = 40;    // worst case incl. 15 stall cycles and a wait for the bus
    localparam int CYCLE_LIMIT = 2 * TXN_COUNT * TXN_CYCLES;

    logic           clk;
    logic           rstN;
    bus_pkg::addr_t awaddr  [MASTERS];
    logic           awvalid [MASTERS];
    logic           awready [MASTERS];
    bus_pkg::data_t wdata   [MASTERS];
    logic           wvalid  [MASTERS];
    logic           wready  [MASTERS];
    bus_pkg::resp_t bresp   [MASTERS];
    logic           bvalid  [MASTERS];
    logic           bready  [MASTERS];
    bus_pkg::addr_t araddr  [MASTERS];
    logic           arvalid [MASTERS];
    logic           arready [MASTERS];
    bus_pkg::data_t rdata   [MASTERS];
    bus_pkg::resp_t rresp   [MASTERS];
    logic           rvalid  [MASTERS];
    logic           rready  [MASTERS];

    bus_pkg::data_t ref_mem [SLAVES][SPAN];     // last value written to each word
    logic [31:0]    lfsr;
    int             check_count, error_count;
    int             test_checks, test_errors;
    int             cycle_count;

    tb_clock_gen u_clock (.clk, .rstN);

    bus_system UUT (
        .clk, .rstN,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int slave_depth(input int s);
        case (s)
            0: return `BUS_SLAVE0_DEPTH;
            1: return `BUS_SLAVE1_DEPTH;
            2: return `BUS_SLAVE2_DEPTH;
            default: return 0;
        endcase
    endfunction

    function automatic bus_pkg::addr_t make_addr(input int sel, input int ofs);
        bus_pkg::slave_sel_t s;
        bus_pkg::offset_t    o;
        s = bus_pkg::slave_sel_t'(sel);
        o = bus_pkg::offset_t'(ofs);
        return {s, o};
    endfunction

    function automatic int sel_of(input bus_pkg::addr_t a);
        return int'(a[ADDR_W-1 -: 2]);
    endfunction

    function automatic int ofs_of(input bus_pkg::addr_t a);
        return int'(a[ADDR_W-3:0]);
    endfunction

    // unmapped select gives DECERR, past the depth gives SLVERR
    function automatic bus_pkg::resp_t expect_resp(input bus_pkg::addr_t a);
        if (sel_of(a) >= SLAVES) return bus_pkg::DECERR;
        if (ofs_of(a) >= slave_depth(sel_of(a))) return bus_pkg::SLVERR;
        return bus_pkg::OKAY;
    endfunction

    function automatic logic resp_valid(input int m, input logic is_write);
        return is_write ? bvalid[m] : rvalid[m];
    endfunction

    task automatic check_data(input string name, input bus_pkg::data_t got,
                              input bus_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input bus_pkg::resp_t got,
                              input bus_pkg::resp_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic start_test;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic report_test(input string name);
        $display("%-16s %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
    endtask

    // wait for B or R, hold ready low for the stall, then take the response
    task automatic take_response(input int m, input logic is_write, input int stall,
                                 output bus_pkg::resp_t r, output bus_pkg::data_t d);
        bus_pkg::resp_t first_resp;
        bus_pkg::data_t first_data;
        string          ch;
        ch = is_write ? "b" : "r";
        #1;
        while (!resp_valid(m, is_write)) begin
            @(negedge clk);
            #1;
        end
        first_resp = is_write ? bresp[m] : rresp[m];
        first_data = rdata[m];
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            #1;
            check_flag($sformatf("%svalid[%0d]", ch, m), resp_valid(m, is_write), 1'b1);
            check_resp($sformatf("%sresp[%0d]", ch, m), is_write ? bresp[m] : rresp[m],
                       first_resp);
            if (!is_write) check_data($sformatf("rdata[%0d]", m), rdata[m], first_data);
            check_flag($sformatf("awready[%0d]", m), awready[m], 1'b0);   // port is full
            check_flag($sformatf("wready[%0d]", m), wready[m], 1'b0);
            check_flag($sformatf("arready[%0d]", m), arready[m], 1'b0);
        end
        @(negedge clk);
        bready[m] = is_write;
        rready[m] = !is_write;
        #1;
        r = is_write ? bresp[m] : rresp[m];
        d = rdata[m];
        @(negedge clk);
        bready[m] = 1'b0;
        rready[m] = 1'b0;
    endtask

    task automatic axi_write(input int m, input bus_pkg::addr_t a, input bus_pkg::data_t d,
                             input int stall, output bus_pkg::resp_t r);
        logic           aw_open;
        logic           w_open;
        bus_pkg::data_t unused;
        aw_open = 1'b1;
        w_open  = 1'b1;
        @(negedge clk);
        awaddr[m]  = a;
        awvalid[m] = 1'b1;
        wdata[m]   = d;
        wvalid[m]  = 1'b1;
        while (aw_open || w_open) begin
            #1;
            if (awvalid[m] && awready[m]) aw_open = 1'b0;  // taken at the next rising edge
            if (wvalid[m] && wready[m]) w_open = 1'b0;
            @(negedge clk);
            if (!aw_open) awvalid[m] = 1'b0;
            if (!w_open) wvalid[m] = 1'b0;
        end
        take_response(m, 1'b1, stall, r, unused);
    endtask

    task automatic axi_read(input int m, input bus_pkg::addr_t a, input int stall,
                            output bus_pkg::resp_t r, output bus_pkg::data_t d);
        logic ar_open;
        ar_open = 1'b1;
        @(negedge clk);
        araddr[m]  = a;
        arvalid[m] = 1'b1;
        while (ar_open) begin
            #1;
            if (arready[m]) ar_open = 1'b0;
            @(negedge clk);
        end
        arvalid[m] = 1'b0;
        take_response(m, 1'b0, stall, r, d);
    endtask

    task automatic write_checked(input int m, input bus_pkg::addr_t a,
                                 input bus_pkg::data_t d, input int stall);
        bus_pkg::resp_t r;
        bus_pkg::resp_t exp;
        exp = expect_resp(a);
        axi_write(m, a, d, stall, r);
        check_resp($sformatf("bresp[%0d]", m), r, exp);
        if (exp == bus_pkg::OKAY) ref_mem[sel_of(a)][ofs_of(a)] = d;
    endtask

    task automatic read_checked(input int m, input bus_pkg::addr_t a, input int stall);
        bus_pkg::resp_t r;
        bus_pkg::resp_t exp;
        bus_pkg::data_t d;
        exp = expect_resp(a);
        axi_read(m, a, stall, r, d);
        check_resp($sformatf("rresp[%0d]", m), r, exp);
        if (exp == bus_pkg::OKAY) check_data($sformatf("rdata[%0d]", m), d,
                                             ref_mem[sel_of(a)][ofs_of(a)]);
        if (exp == bus_pkg::DECERR) check_data($sformatf("rdata[%0d]", m), d, '0);
    endtask

    task automatic test_reset;
        start_test();
        @(negedge clk);
        #1;
        for (int m = 0; m < MASTERS; m++) begin
            check_flag($sformatf("bvalid[%0d]", m), bvalid[m], 1'b0);
            check_flag($sformatf("rvalid[%0d]", m), rvalid[m], 1'b0);
            check_flag($sformatf("awready[%0d]", m), awready[m], 1'b1);
            check_flag($sformatf("wready[%0d]", m), wready[m], 1'b1);
            check_flag($sformatf("arready[%0d]", m), arready[m], 1'b1);
        end
        report_test("reset_state");
    endtask

    task automatic test_write_read;
        int spots [4];
        start_test();
        for (int s = 0; s < SLAVES; s++) begin
            spots = '{0, 1, 'h2a5 + s, slave_depth(s) - 1};
            for (int k = 0; k < 4; k++) begin
                write_checked(0, make_addr(s, spots[k]), bus_pkg::data_t'(take_bits(16)), 0);
            end
            for (int k = 0; k < 4; k++) begin
                read_checked(0, make_addr(s, spots[k]), 0);
            end
        end
        report_test("write_read");
    endtask

    task automatic test_contention;
        bus_pkg::addr_t a;
        bus_pkg::resp_t r0, r1;
        bus_pkg::data_t v0, v1;
        start_test();
        fork
            write_checked(0, make_addr(0, 'h100), 16'h0f0f, 0);
            write_checked(1, make_addr(1, 'h200), 16'hf0f0, 0);
        join
        read_checked(1, make_addr(0, 'h100), 0);
        read_checked(0, make_addr(1, 'h200), 0);
        a = make_addr(2, 'h040);                // both masters on one word
        fork
            axi_write(0, a, 16'ha5a5, 0, r0);
            axi_write(1, a, 16'h5a5a, 0, r1);
        join
        check_resp("bresp[0]", r0, bus_pkg::OKAY);
        check_resp("bresp[1]", r1, bus_pkg::OKAY);
        fork
            axi_read(0, a, 0, r0, v0);
            axi_read(1, a, 0, r1, v1);
        join
        check_resp("rresp[0]", r0, bus_pkg::OKAY);
        check_resp("rresp[1]", r1, bus_pkg::OKAY);
        check_data("rdata[1]", v1, v0);
        check_count++;
        if (v0 !== 16'ha5a5 && v0 !== 16'h5a5a) begin
            error_count++;
            $display("Error: rdata[0] = 0x%h, expected 0xa5a5 or 0x5a5a", v0);
        end
        ref_mem[2][ofs_of(a)] = v0;
        report_test("contention");
    endtask

    task automatic test_error_responses;
        start_test();
        read_checked(1, make_addr(2, 2048), 0);
        write_checked(1, make_addr(2, 2048), 16'hdead, 0);  // would alias onto offset 0
        read_checked(1, make_addr(2, 0), 0);
        write_checked(1, make_addr(2, 'hfff), 16'hbeef, 0);
        read_checked(1, make_addr(2, 2047), 0);
        write_checked(0, make_addr(3, 'h010), 16'h1234, 0);
        read_checked(1, make_addr(3, 'h020), 0);
        report_test("error_responses");
    endtask

    task automatic traffic(input int m, input int pairs);
        bus_pkg::addr_t a;
        for (int i = 0; i < pairs; i++) begin
            // offset bit 10 keeps the two masters on separate words
            a = make_addr((m + i) % SLAVES, m * 1024 + take_bits(10));
            write_checked(m, a, bus_pkg::data_t'(take_bits(16)), take_bits(4));
            read_checked(m, a, take_bits(4));
        end
    endtask

    task automatic test_backpressure;
        start_test();
        fork
            traffic(0, 3);
            traffic(1, 3);
        join
        report_test("backpressure");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        lfsr        = 32'hd689;
        check_count = 0;
        error_count = 0;
        for (int m = 0; m < MASTERS; m++) begin
            awaddr[m]  = '0;
            awvalid[m] = 1'b0;
            wdata[m]   = '0;
            wvalid[m]  = 1'b0;
            bready[m]  = 1'b0;
            araddr[m]  = '0;
            arvalid[m] = 1'b0;
            rready[m]  = 1'b0;
        end
        wait (rstN === 1'b1);
        test_reset();
        test_write_read();
        test_contention();
        test_error_responses();
        test_backpressure();
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/bus_system_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module bus_system_props (
    input logic                         clk,
    input logic                         rstN,
    input logic [`BUS_MASTER_COUNT-1:0] grant,
    input logic                         bvalid [`BUS_MASTER_COUNT],
    input logic                         bready [`BUS_MASTER_COUNT],
    input bus_pkg::resp_t               bresp  [`BUS_MASTER_COUNT],
    input logic                         rvalid [`BUS_MASTER_COUNT],
    input logic                         rready [`BUS_MASTER_COUNT],
    input bus_pkg::data_t               rdata  [`BUS_MASTER_COUNT],
    input bus_pkg::resp_t               rresp  [`BUS_MASTER_COUNT]
);

    // one transfer owns the bus at a time
    grant_onehot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
        else $error("more than one master granted, grant = %b", grant);

    for (genvar m = 0; m < `BUS_MASTER_COUNT; m++) begin : g_master
        b_hold: assert property (@(posedge clk) disable iff (!rstN)
            bvalid[m] && !bready[m] |=> bvalid[m] && $stable(bresp[m]))
            else $error("write response on master %0d dropped or changed before bready", m);

        r_hold: assert property (@(posedge clk) disable iff (!rstN)
            rvalid[m] && !rready[m] |=> rvalid[m] && $stable(rdata[m]) && $stable(rresp[m]))
            else $error("read response on master %0d dropped or changed before rready", m);

        // no response may appear while reset is held
        reset_quiet: assert property (@(posedge clk) !rstN |-> !bvalid[m] && !rvalid[m])
            else $error("response valid on master %0d during reset", m);
    end

endmodule

bind bus_system bus_system_props u_props (
    .clk(clk),
    .rstN(rstN),
    .grant(grant),
    .bvalid(bvalid),
    .bready(bready),
    .bresp(bresp),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .rresp(rresp)
);

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release falls on a falling edge, clear of the rising edge
    initial begin
        rstN = 1'b0;
        #(PERIOD_NS * RESET_CYCLES) rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/bus_system.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module bus_system (
    input  logic           clk,
    input  logic           rstN,
    input  bus_pkg::addr_t awaddr  [`BUS_MASTER_COUNT],
    input  logic           awvalid [`BUS_MASTER_COUNT],
    output logic           awready [`BUS_MASTER_COUNT],
    input  bus_pkg::data_t wdata   [`BUS_MASTER_COUNT],
    input  logic           wvalid  [`BUS_MASTER_COUNT],
    output logic           wready  [`BUS_MASTER_COUNT],
    output bus_pkg::resp_t bresp   [`BUS_MASTER_COUNT],
    output logic           bvalid  [`BUS_MASTER_COUNT],
    input  logic           bready  [`BUS_MASTER_COUNT],
    input  bus_pkg::addr_t araddr  [`BUS_MASTER_COUNT],
    input  logic           arvalid [`BUS_MASTER_COUNT],
    output logic           arready [`BUS_MASTER_COUNT],
    output bus_pkg::data_t rdata   [`BUS_MASTER_COUNT],
    output bus_pkg::resp_t rresp   [`BUS_MASTER_COUNT],
    output logic           rvalid  [`BUS_MASTER_COUNT],
    input  logic           rready  [`BUS_MASTER_COUNT]
);

    localparam int MASTERS = `BUS_MASTER_COUNT;
    localparam int SLAVES  = `BUS_SLAVE_COUNT;
    localparam int DEPTHS [SLAVES] = '{`BUS_SLAVE0_DEPTH, `BUS_SLAVE1_DEPTH, `BUS_SLAVE2_DEPTH};
    localparam int WAITS  [SLAVES] = '{`BUS_SLAVE0_WAIT, `BUS_SLAVE1_WAIT, `BUS_SLAVE2_WAIT};

    logic [MASTERS-1:0]  bus_req, bus_write, grant;
    bus_pkg::addr_t      bus_addr  [MASTERS];
    bus_pkg::data_t      bus_wdata [MASTERS];
    bus_pkg::master_id_t grant_id;

    logic [SLAVES-1:0]   sel_strb, slv_done;
    logic                slv_write, dec_err;
    bus_pkg::offset_t    slv_offset;
    bus_pkg::data_t      slv_wdata;
    bus_pkg::data_t      slv_rdata [SLAVES];
    bus_pkg::resp_t      slv_resp  [SLAVES];

    logic                xfer_done;
    bus_pkg::data_t      xfer_rdata;
    bus_pkg::resp_t      xfer_resp;

    for (genvar m = 0; m < MASTERS; m++) begin : g_port
        axil_port u_port (
            .clk, .rstN,
            .awaddr(awaddr[m]), .awvalid(awvalid[m]), .awready(awready[m]),
            .wdata(wdata[m]), .wvalid(wvalid[m]), .wready(wready[m]),
            .bresp(bresp[m]), .bvalid(bvalid[m]), .bready(bready[m]),
            .araddr(araddr[m]), .arvalid(arvalid[m]), .arready(arready[m]),
            .rdata(rdata[m]), .rresp(rresp[m]), .rvalid(rvalid[m]), .rready(rready[m]),
            .bus_req(bus_req[m]), .bus_write(bus_write[m]),
            .bus_addr(bus_addr[m]), .bus_wdata(bus_wdata[m]),
            .granted(grant[m]), .xfer_done, .xfer_rdata, .xfer_resp
        );
    end

    bus_arbiter u_arbiter (.clk, .rstN, .bus_req, .xfer_done, .grant, .grant_id);

    slave_decoder u_decoder (
        .clk, .rstN, .grant_id, .grant, .bus_req, .bus_write, .bus_addr, .bus_wdata,
        .sel_strb, .slv_write, .slv_offset, .slv_wdata, .dec_err
    );

    for (genvar s = 0; s < SLAVES; s++) begin : g_slave
        mem_slave #(.DEPTH(DEPTHS[s]), .WAIT(WAITS[s])) u_slave (
            .clk, .rstN, .strb(sel_strb[s]), .write(slv_write), .offset(slv_offset),
            .wdata(slv_wdata), .done(slv_done[s]), .rdata(slv_rdata[s]), .resp(slv_resp[s])
        );
    end

    response_mux u_mux (
        .clk, .rstN, .done(slv_done), .rdata(slv_rdata), .resp(slv_resp), .dec_err,
        .xfer_done, .xfer_rdata, .xfer_resp
    );

endmodule

`default_nettype wire

// ==== verilog/response_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module response_mux (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [`BUS_SLAVE_COUNT-1:0] done,
    input  bus_pkg::data_t              rdata [`BUS_SLAVE_COUNT],
    input  bus_pkg::resp_t              resp  [`BUS_SLAVE_COUNT],
    input  logic                        dec_err,
    output logic                        xfer_done,
    output bus_pkg::data_t              xfer_rdata,
    output bus_pkg::resp_t              xfer_resp
);

    bus_pkg::data_t sel_rdata;
    bus_pkg::resp_t sel_resp;

    // at most one slave finishes per transfer; no done means decode error
    always_comb begin
        sel_rdata = '0;
        sel_resp  = bus_pkg::DECERR;
        for (int s = 0; s < `BUS_SLAVE_COUNT; s++) begin
            if (done[s]) begin
                sel_rdata = rdata[s];
                sel_resp  = resp[s];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) xfer_done <= 1'b0;
        else xfer_done <= (|done) || dec_err;   // one cycle pulse
    end

    always_ff @(posedge clk) begin
        if ((|done) || dec_err) begin
            xfer_rdata <= sel_rdata;
            xfer_resp  <= sel_resp;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_slave #(
    parameter int DEPTH = 4096,
    parameter int WAIT  = 0
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             strb,
    input  logic             write,
    input  bus_pkg::offset_t offset,
    input  bus_pkg::data_t   wdata,
    output logic             done,
    output bus_pkg::data_t   rdata,
    output bus_pkg::resp_t   resp
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    bus_pkg::data_t   mem [DEPTH];
    logic             busy;
    logic [CW-1:0]    cnt;              // wait cycles still to go
    logic             req_write;
    bus_pkg::offset_t req_offset;
    bus_pkg::data_t   req_wdata;
    logic             go;
    logic             op_write;
    bus_pkg::offset_t op_offset;
    bus_pkg::data_t   op_wdata;
    logic             in_range;

    // a zero-wait slave acts on the strobe cycle itself
    assign go        = strb ? (WAIT == 0) : (busy && cnt == '0);
    assign op_write  = strb ? write : req_write;
    assign op_offset = strb ? offset : req_offset;
    assign op_wdata  = strb ? wdata : req_wdata;
    assign in_range  = int'(op_offset) < DEPTH;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= go;
            if (strb && WAIT != 0) begin
                busy <= 1'b1;
                cnt  <= CW'(WAIT - 1);
            end else if (busy) begin
                if (cnt == '0) busy <= 1'b0;
                else cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strb) begin
            req_write  <= write;
            req_offset <= offset;
            req_wdata  <= wdata;
        end
        if (go) begin
            if (in_range) begin
                if (op_write) mem[op_offset[AW-1:0]] <= op_wdata;
                else rdata <= mem[op_offset[AW-1:0]];
                resp <= bus_pkg::OKAY;
            end else begin
                rdata <= '0;                // memory untouched past the depth
                resp  <= bus_pkg::SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/slave_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module slave_decoder (
    input  logic                         clk,
    input  logic                         rstN,
    input  bus_pkg::master_id_t          grant_id,
    input  logic [`BUS_MASTER_COUNT-1:0] grant,
    input  logic [`BUS_MASTER_COUNT-1:0] bus_req,
    input  logic [`BUS_MASTER_COUNT-1:0] bus_write,
    input  bus_pkg::addr_t               bus_addr  [`BUS_MASTER_COUNT],
    input  bus_pkg::data_t               bus_wdata [`BUS_MASTER_COUNT],
    output logic [`BUS_SLAVE_COUNT-1:0]  sel_strb,
    output logic                         slv_write,
    output bus_pkg::offset_t             slv_offset,
    output bus_pkg::data_t               slv_wdata,
    output logic                         dec_err
);

    localparam int SLAVES = `BUS_SLAVE_COUNT;
    localparam int OFS_W  = $bits(bus_pkg::offset_t);

    logic                granted_q;     // grant seen last cycle
    logic                new_grant;
    bus_pkg::slave_sel_t sel;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) granted_q <= 1'b0;
        else granted_q <= |grant;
    end

    // first cycle of a grant only, so each transfer strobes once
    assign new_grant = (|grant) && !granted_q && bus_req[grant_id];

    assign sel        = bus_addr[grant_id][`BUS_ADDR_WIDTH-1 -: 2];
    assign slv_offset = bus_addr[grant_id][OFS_W-1:0];
    assign slv_write  = bus_write[grant_id];
    assign slv_wdata  = bus_wdata[grant_id];

    always_comb begin
        sel_strb = '0;
        dec_err  = 1'b0;
        if (new_grant) begin
            if (int'(sel) < SLAVES) sel_strb[sel] = 1'b1;
            else dec_err = 1'b1;    // select code with no slave behind it
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_system_config.svh"

module bus_arbiter (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [`BUS_MASTER_COUNT-1:0] bus_req,
    input  logic                         xfer_done,
    output logic [`BUS_MASTER_COUNT-1:0] grant,
    output bus_pkg::master_id_t          grant_id
);

    localparam int MASTERS = `BUS_MASTER_COUNT;

    bus_pkg::master_id_t last_id;       // master served most recently
    bus_pkg::master_id_t pick_id;
    bus_pkg::master_id_t cand;
    logic                pick_found;
    logic                busy;

    // search starts just after the last master served
    always_comb begin
        pick_found = 1'b0;
        pick_id    = last_id;
        cand       = last_id;
        for (int i = 1; i <= MASTERS; i++) begin
            cand = bus_pkg::master_id_t'((int'(last_id) + i) % MASTERS);
            if (!pick_found && bus_req[cand]) begin
                pick_found = 1'b1;
                pick_id    = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy     <= 1'b0;
            grant    <= '0;
            grant_id <= '0;
            last_id  <= bus_pkg::master_id_t'(MASTERS - 1);  // master 0 goes first
        end else if (busy) begin
            if (xfer_done) begin            // grant drops the cycle after done
                busy    <= 1'b0;
                grant   <= '0;
                last_id <= grant_id;
            end
        end else if (pick_found) begin
            busy     <= 1'b1;
            grant    <= MASTERS'(1) << pick_id;
            grant_id <= pick_id;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axil_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_port (
    input  logic               clk,
    input  logic               rstN,
    // write address
    input  bus_pkg::addr_t     awaddr,
    input  logic               awvalid,
    output logic               awready,
    // write data
    input  bus_pkg::data_t     wdata,
    input  logic               wvalid,
    output logic               wready,
    // write response
    output bus_pkg::resp_t     bresp,
    output logic               bvalid,
    input  logic               bready,
    // read address
    input  bus_pkg::addr_t     araddr,
    input  logic               arvalid,
    output logic               arready,
    // read data
    output bus_pkg::data_t     rdata,
    output bus_pkg::resp_t     rresp,
    output logic               rvalid,
    input  logic               rready,
    // toward arbiter and decoder
    output logic               bus_req,
    output logic               bus_write,
    output bus_pkg::addr_t     bus_addr,
    output bus_pkg::data_t     bus_wdata,
    // back from the response mux
    input  logic               granted,
    input  logic               xfer_done,
    input  bus_pkg::data_t     xfer_rdata,
    input  bus_pkg::resp_t     xfer_resp
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

    state_t         state;
    logic           aw_got, w_got;      // halves of a write seen so far
    logic           aw_hs, w_hs, ar_hs;
    logic           wr_fire, finish;
    logic           req_write;
    bus_pkg::addr_t req_addr;
    bus_pkg::data_t req_wdata;
    bus_pkg::data_t rdata_q;
    bus_pkg::resp_t resp_q;

    // only one transaction per port, ready stays low while one is held
    assign awready = (state == ST_IDLE) && !aw_got;
    assign wready  = (state == ST_IDLE) && !w_got;
    // writes win, so a read waits while any part of a write is pending
    assign arready = (state == ST_IDLE) && !aw_got && !w_got && !awvalid && !wvalid;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign ar_hs   = arvalid && arready;
    assign wr_fire = (aw_hs || aw_got) && (w_hs || w_got);
    assign finish  = (state == ST_REQ) && granted && xfer_done;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= ST_IDLE;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_fire) begin
                        state  <= ST_REQ;
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                    end else begin
                        if (aw_hs) aw_got <= 1'b1;
                        if (w_hs) w_got <= 1'b1;
                        if (ar_hs) state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (finish) state <= ST_RESP;
                end
                ST_RESP: begin
                    if (req_write ? bready : rready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // captured request and returned result
    always_ff @(posedge clk) begin
        if (aw_hs) req_addr <= awaddr;
        else if (ar_hs) req_addr <= araddr;
        if (w_hs) req_wdata <= wdata;
        if (wr_fire) req_write <= 1'b1;
        else if (ar_hs) req_write <= 1'b0;
        if (finish) begin
            resp_q  <= xfer_resp;
            rdata_q <= xfer_rdata;
        end
    end

    assign bus_req   = (state == ST_REQ);
    assign bus_write = req_write;
    assign bus_addr  = req_addr;
    assign bus_wdata = req_wdata;

    assign bvalid = (state == ST_RESP) && req_write;
    assign rvalid = (state == ST_RESP) && !req_write;
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
`default_nettype none

`include "bus_system_config.svh"

package bus_pkg;

    // one data word on the bus
    typedef logic [`BUS_DATA_WIDTH-1:0] data_t;

    // word address: slave select on top, word offset below
    typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;
    typedef logic [1:0]                 slave_sel_t;
    typedef logic [`BUS_ADDR_WIDTH-3:0] offset_t;

    typedef logic [$clog2(`BUS_MASTER_COUNT)-1:0] master_id_t;

    // AXI response codes, EXOKAY is never produced here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

// ==== verilog/bus_system_config.svh ====
`ifndef BUS_SYSTEM_CONFIG_SVH
`define BUS_SYSTEM_CONFIG_SVH

// bus widths
`define BUS_DATA_WIDTH   16
`define BUS_ADDR_WIDTH   14     // 2 select bits over a 12 bit word offset

// bus population
`define BUS_MASTER_COUNT 2
`define BUS_SLAVE_COUNT  3

// slave depths in words
`define BUS_SLAVE0_DEPTH 4096
`define BUS_SLAVE1_DEPTH 4096
`define BUS_SLAVE2_DEPTH 2048

// extra wait cycles before a slave answers
`define BUS_SLAVE0_WAIT  0
`define BUS_SLAVE1_WAIT  0
`define BUS_SLAVE2_WAIT  4

`endif
